//--- files.f
+incdir+source
source/cache_be_mem_pkg.sv
source/cache_be_line_pkg.sv
source/cache_be_word_counter.sv
source/cache_be_read_fsm.sv
source/cache_be_write_channel.sv
source/cache_be_bus_arbiter.sv
source/cache_be_top.sv
verif/cache_be_mem_model.sv
verif/cache_be_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the cache back end testbench with Verilator
# the log is searched for the pass line to decide the exit status

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f files.f --top-module cache_be_tb -o cache_be_sim \
   && ./obj_dir/cache_be_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qx "Regression passed" sim.log \
   && echo "run.sh: simulation ok" \
   || { echo "run.sh: simulation reported errors"; exit 1; }

//--- source/cache_be_bus_arbiter.sv
// two requesters on one bus, read wins when both ask while the bus is free
// one transaction outstanding, no new request until the owner sees its ack
`timescale 1ns/100ps

module cache_be_bus_arbiter (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   // read channel
   input  logic                        rd_valid_i,
   input  cache_be_mem_pkg::mem_addr_t rd_addr_i,
   // write channel
   input  logic                        wr_valid_i,
   input  cache_be_mem_pkg::mem_addr_t wr_addr_i,
   input  cache_be_mem_pkg::mem_data_t wr_wdata_i,
   input  cache_be_mem_pkg::mem_strb_t wr_strb_i,
   // memory responses
   input  logic                        mem_ready_i,
   input  logic                        mem_rvalid_i,
   // per channel accept and completion
   output logic                        rd_grant_o,
   output logic                        rd_ack_o,
   output logic                        wr_grant_o,
   output logic                        wr_ack_o,
   // memory request
   output logic                        mem_valid_o,
   output cache_be_mem_pkg::mem_addr_t mem_addr_o,
   output cache_be_mem_pkg::mem_data_t mem_wdata_o,
   output cache_be_mem_pkg::mem_strb_t mem_wstrb_o
);

   import cache_be_mem_pkg::*;

   // accepted, waiting for the ack
   logic lock_q;
   // shown but not yet accepted, selection frozen
   logic park_q;
   // owner of the shown or accepted request, 1 is read
   logic own_rd_q;
   // write acceptance one cycle late
   logic wack_q;
   logic sel_rd;
   logic accept;

   // a parked request keeps its owner, else read first
   assign sel_rd = park_q ? own_rd_q : rd_valid_i;

   assign mem_valid_o = ~lock_q & (rd_valid_i | wr_valid_i);
   assign mem_addr_o  = sel_rd ? rd_addr_i : wr_addr_i;
   assign mem_wdata_o = sel_rd ? mem_data_t'('0) : wr_wdata_i;
   // zero strobes make it a read
   assign mem_wstrb_o = sel_rd ? mem_strb_t'('0) : wr_strb_i;

   assign accept     = mem_valid_o & mem_ready_i;
   assign rd_grant_o = accept & sel_rd;
   assign wr_grant_o = accept & ~sel_rd;

   // rvalid only counts for a read owner
   assign rd_ack_o = lock_q & own_rd_q & mem_rvalid_i;
   assign wr_ack_o = wack_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lock_q   <= 1'b0;
         park_q   <= 1'b0;
         own_rd_q <= 1'b0;
         wack_q   <= 1'b0;
      end else begin
         wack_q <= wr_grant_o;
         if (mem_valid_o) begin
            own_rd_q <= sel_rd;
         end
         if (accept) begin
            lock_q <= 1'b1;
            park_q <= 1'b0;
         end else begin
            if (mem_valid_o) begin
               park_q <= 1'b1;
            end
            // release on the owner's ack
            if (rd_ack_o | wr_ack_o) begin
               lock_q <= 1'b0;
            end
         end
      end
   end

endmodule

//--- source/cache_be_line_pkg.sv
// cache side address types, all cut from the bus byte address
// line address keeps only the bits above word index and byte offset
`include "cache_be_macros.svh"

package cache_be_line_pkg;

   // line address, byte address without word index and byte offset
   typedef logic [`CACHE_BE_ADDR_W-`CACHE_BE_WORD_OFFSET_W-`CACHE_BE_NBYTES_W-1:0]
      line_addr_t;

   // word address of a write-through store
   // byte address without byte offset
   typedef logic [`CACHE_BE_ADDR_W-`CACHE_BE_NBYTES_W-1:0] word_addr_t;

   // word index inside one line
   typedef logic [`CACHE_BE_WORD_OFFSET_W-1:0] word_idx_t;

endpackage

//--- source/cache_be_macros.svh
// widths and line geometry for the cache back end
// one word width on both sides, so a line is 2**WORD_OFFSET_W bus words
`ifndef CACHE_BE_MACROS_SVH
`define CACHE_BE_MACROS_SVH

// byte address on the memory bus
`define CACHE_BE_ADDR_W 16

// word width, cache side and memory side
`define CACHE_BE_DATA_W 32

// byte offset bits inside one word
`define CACHE_BE_NBYTES_W 2

// word index bits inside one line
// 2 gives 4 words per line
`define CACHE_BE_WORD_OFFSET_W 2

`endif

//--- source/cache_be_mem_pkg.sv
// memory bus side types, byte addressed, one word per transfer
// strobes of all zero mark a read
`include "cache_be_macros.svh"

package cache_be_mem_pkg;

   // full byte address as seen on the bus
   // low NBYTES_W bits always zero here
   typedef logic [`CACHE_BE_ADDR_W-1:0] mem_addr_t;

   // read and write data
   typedef logic [`CACHE_BE_DATA_W-1:0] mem_data_t;

   // one strobe per byte lane
   // lane 0 is the low byte
   typedef logic [`CACHE_BE_DATA_W/8-1:0] mem_strb_t;

endpackage

//--- source/cache_be_read_fsm.sv
// line fill, one bus read per word, words returned in order 0 up
// replace_valid_i only sampled while idle, a new fill needs idle again
`timescale 1ns/100ps
`include "cache_be_macros.svh"

module cache_be_read_fsm (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   // replacement request from the cache
   input  logic                          replace_valid_i,
   input  cache_be_line_pkg::line_addr_t replace_addr_i,
   // word counter
   input  cache_be_line_pkg::word_idx_t  word_idx_i,
   input  logic                          last_i,
   // arbiter side
   input  logic                          grant_i,
   input  logic                          ack_i,
   input  cache_be_mem_pkg::mem_data_t   rdata_i,
   // back to the cache
   output logic                          replace_o,
   output logic                          read_valid_o,
   output cache_be_line_pkg::word_idx_t  read_addr_o,
   output cache_be_mem_pkg::mem_data_t   read_rdata_o,
   // counter control
   output logic                          cnt_clear_o,
   output logic                          cnt_inc_o,
   // request toward the arbiter
   output logic                          req_valid_o,
   output cache_be_mem_pkg::mem_addr_t   req_addr_o
);

   import cache_be_mem_pkg::*;
   import cache_be_line_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQUEST,
      ST_WAIT_DATA,
      ST_DONE
   } state_t;

   state_t     state_q;
   state_t     state_d;
   line_addr_t line_addr_q;
   word_idx_t  word_idx_q;
   mem_data_t  rdata_q;
   logic       rvalid_q;
   logic       take_line;
   logic       word_done;

   // line accepted from the cache
   assign take_line = (state_q == ST_IDLE) & replace_valid_i;
   // read data back from memory
   assign word_done = (state_q == ST_WAIT_DATA) & ack_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (replace_valid_i) begin
               state_d = ST_REQUEST;
            end
         end
         ST_REQUEST: begin
            // bus took the read
            if (grant_i) begin
               state_d = ST_WAIT_DATA;
            end
         end
         ST_WAIT_DATA: begin
            if (ack_i) begin
               state_d = last_i ? ST_DONE : ST_REQUEST;
            end
         end
         // holds replace_o over the last word pulse
         ST_DONE: state_d = ST_IDLE;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= ST_IDLE;
         rvalid_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         rvalid_q <= word_done;
      end
   end

   // line address and the returned word with its index
   always_ff @(posedge clk_i) begin
      if (take_line) begin
         line_addr_q <= replace_addr_i;
      end
      if (word_done) begin
         word_idx_q <= word_idx_i;
         rdata_q    <= rdata_i;
      end
   end

   // counter restarts with each line
   assign cnt_clear_o = take_line;
   // no step after the last word, counter already at the end
   assign cnt_inc_o   = word_done & ~last_i;

   assign req_valid_o = (state_q == ST_REQUEST);
   // word aligned byte address
   assign req_addr_o  = {line_addr_q, word_idx_i, {`CACHE_BE_NBYTES_W{1'b0}}};

   assign replace_o    = (state_q != ST_IDLE);
   assign read_valid_o = rvalid_q;
   assign read_addr_o  = word_idx_q;
   assign read_rdata_o = rdata_q;

endmodule

//--- source/cache_be_top.sv
// write-through cache back end on one memory bus
// no write-back, no clock enable, equal data widths on both sides
`timescale 1ns/100ps

module cache_be_top (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   // write-through stores
   input  logic                          write_valid_i,
   input  cache_be_line_pkg::word_addr_t write_addr_i,
   input  cache_be_mem_pkg::mem_data_t   write_wdata_i,
   input  cache_be_mem_pkg::mem_strb_t   write_wstrb_i,
   output logic                          write_ready_o,
   // line replacement
   input  logic                          replace_valid_i,
   input  cache_be_line_pkg::line_addr_t replace_addr_i,
   output logic                          replace_o,
   output logic                          read_valid_o,
   output cache_be_line_pkg::word_idx_t  read_addr_o,
   output cache_be_mem_pkg::mem_data_t   read_rdata_o,
   // memory bus
   output logic                          mem_valid_o,
   output cache_be_mem_pkg::mem_addr_t   mem_addr_o,
   output cache_be_mem_pkg::mem_data_t   mem_wdata_o,
   output cache_be_mem_pkg::mem_strb_t   mem_wstrb_o,
   input  logic                          mem_ready_i,
   input  cache_be_mem_pkg::mem_data_t   mem_rdata_i,
   input  logic                          mem_rvalid_i
);

   import cache_be_mem_pkg::*;
   import cache_be_line_pkg::*;

   // read channel to arbiter
   logic      rd_req_valid;
   mem_addr_t rd_req_addr;
   logic      rd_grant;
   logic      rd_ack;

   // write channel to arbiter
   logic      wr_req_valid;
   mem_addr_t wr_req_addr;
   mem_data_t wr_req_wdata;
   mem_strb_t wr_req_wstrb;
   logic      wr_grant;
   logic      wr_ack;

   // fill position
   logic      cnt_clear;
   logic      cnt_inc;
   word_idx_t word_idx;
   logic      last_word;

   cache_be_read_fsm u_read_fsm (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .word_idx_i     (word_idx),
      .last_i         (last_word),
      .grant_i        (rd_grant),
      .ack_i          (rd_ack),
      .rdata_i        (mem_rdata_i),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_addr_o    (read_addr_o),
      .read_rdata_o   (read_rdata_o),
      .cnt_clear_o    (cnt_clear),
      .cnt_inc_o      (cnt_inc),
      .req_valid_o    (rd_req_valid),
      .req_addr_o     (rd_req_addr)
   );

   cache_be_word_counter u_word_counter (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .clear_i   (cnt_clear),
      .inc_i     (cnt_inc),
      .word_idx_o(word_idx),
      .last_o    (last_word)
   );

   cache_be_write_channel u_write_channel (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .write_valid_i(write_valid_i),
      .write_addr_i (write_addr_i),
      .write_wdata_i(write_wdata_i),
      .write_wstrb_i(write_wstrb_i),
      .write_ready_o(write_ready_o),
      .grant_i      (wr_grant),
      .ack_i        (wr_ack),
      .req_valid_o  (wr_req_valid),
      .req_addr_o   (wr_req_addr),
      .req_wdata_o  (wr_req_wdata),
      .req_wstrb_o  (wr_req_wstrb)
   );

   cache_be_bus_arbiter u_bus_arbiter (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .rd_valid_i  (rd_req_valid),
      .rd_addr_i   (rd_req_addr),
      .wr_valid_i  (wr_req_valid),
      .wr_addr_i   (wr_req_addr),
      .wr_wdata_i  (wr_req_wdata),
      .wr_strb_i   (wr_req_wstrb),
      .mem_ready_i (mem_ready_i),
      .mem_rvalid_i(mem_rvalid_i),
      .rd_grant_o  (rd_grant),
      .rd_ack_o    (rd_ack),
      .wr_grant_o  (wr_grant),
      .wr_ack_o    (wr_ack),
      .mem_valid_o (mem_valid_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o),
      .mem_wstrb_o (mem_wstrb_o)
   );

endmodule

//--- source/cache_be_word_counter.sv
// word position of a line fill
// clear wins over inc, index wraps after the last word
`timescale 1ns/100ps

module cache_be_word_counter (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   // start of a fill
   input  logic                         clear_i,
   // one word returned
   input  logic                         inc_i,
   output cache_be_line_pkg::word_idx_t word_idx_o,
   output logic                         last_o
);

   import cache_be_line_pkg::*;

   // index of the next word to fetch
   word_idx_t idx_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         idx_q <= '0;
      end else if (clear_i) begin
         idx_q <= '0;
      end else if (inc_i) begin
         idx_q <= idx_q + word_idx_t'(1);
      end
   end

   assign word_idx_o = idx_q;

   // all ones is the final word of the line
   assign last_o = (idx_q == '1);

endmodule

//--- source/cache_be_write_channel.sv
// single entry write-through buffer, one strobed bus write per store
// write_ready_o stays low from store until the write ack is seen
`timescale 1ns/100ps
`include "cache_be_macros.svh"

module cache_be_write_channel (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   // store from the cache
   input  logic                          write_valid_i,
   input  cache_be_line_pkg::word_addr_t write_addr_i,
   input  cache_be_mem_pkg::mem_data_t   write_wdata_i,
   input  cache_be_mem_pkg::mem_strb_t   write_wstrb_i,
   output logic                          write_ready_o,
   // arbiter side
   input  logic                          grant_i,
   input  logic                          ack_i,
   output logic                          req_valid_o,
   output cache_be_mem_pkg::mem_addr_t   req_addr_o,
   output cache_be_mem_pkg::mem_data_t   req_wdata_o,
   output cache_be_mem_pkg::mem_strb_t   req_wstrb_o
);

   import cache_be_mem_pkg::*;
   import cache_be_line_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQUEST,
      ST_WAIT_ACK
   } state_t;

   state_t     state_q;
   word_addr_t addr_q;
   mem_data_t  wdata_q;
   mem_strb_t  wstrb_q;
   logic       take_store;

   assign take_store = write_valid_i & write_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (take_store) begin
                  state_q <= ST_REQUEST;
               end
            end
            // shown on the bus until accepted
            ST_REQUEST: begin
               if (grant_i) begin
                  state_q <= ST_WAIT_ACK;
               end
            end
            // registered acceptance closes the write
            ST_WAIT_ACK: begin
               if (ack_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // store held until the next one is taken
   always_ff @(posedge clk_i) begin
      if (take_store) begin
         addr_q  <= write_addr_i;
         wdata_q <= write_wdata_i;
         wstrb_q <= write_wstrb_i;
      end
   end

   assign write_ready_o = (state_q == ST_IDLE);
   assign req_valid_o   = (state_q == ST_REQUEST);
   // byte offset zero on the bus
   assign req_addr_o    = {addr_q, {`CACHE_BE_NBYTES_W{1'b0}}};
   assign req_wdata_o   = wdata_q;
   assign req_wstrb_o   = wstrb_q;

endmodule

//--- verif/cache_be_mem_model.sv
// word memory for the cache back end testbench, byte strobes merge writes
// one read outstanding, outputs change only on the falling clock edge
`timescale 1ns/100ps
`include "cache_be_macros.svh"

module cache_be_mem_model (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           mem_valid_i,
   input  logic [`CACHE_BE_ADDR_W-1:0]    mem_addr_i,
   input  logic [`CACHE_BE_DATA_W-1:0]    mem_wdata_i,
   input  logic [`CACHE_BE_DATA_W/8-1:0]  mem_wstrb_i,
   output logic                           mem_ready_o,
   output logic [`CACHE_BE_DATA_W-1:0]    mem_rdata_o,
   output logic                           mem_rvalid_o
);

   localparam int WORDS = 1 << (`CACHE_BE_ADDR_W - `CACHE_BE_NBYTES_W);

   logic [`CACHE_BE_DATA_W-1:0]                   mem [0:WORDS-1];
   logic [`CACHE_BE_ADDR_W-`CACHE_BE_NBYTES_W-1:0] rd_word;
   logic [`CACHE_BE_ADDR_W-1:0]                   byte_addr;
   logic [31:0]                                   rnd;
   logic                                          rd_pend;
   int                                            rd_wait;
   integer                                        seed;

   initial begin
      seed = 62;
      // upper half byte address, lower half its inverse
      for (int i = 0; i < WORDS; i++) begin
         byte_addr = {i[`CACHE_BE_ADDR_W-`CACHE_BE_NBYTES_W-1:0], {`CACHE_BE_NBYTES_W{1'b0}}};
         mem[i]    = {byte_addr, ~byte_addr};
      end
      mem_ready_o  = 1'b0;
      mem_rvalid_o = 1'b0;
      mem_rdata_o  = '0;
      rd_pend      = 1'b0;
      rd_wait      = 0;
      rd_word      = '0;
      forever begin
         @(negedge clk_i);
         // read data goes out once the random wait has run down
         mem_rvalid_o = 1'b0;
         if (rd_pend) begin
            if (rd_wait == 0) begin
               mem_rvalid_o = 1'b1;
               mem_rdata_o  = mem[rd_word];
               rd_pend      = 1'b0;
            end else begin
               rd_wait = rd_wait - 1;
            end
         end
         rnd         = $random(seed);
         mem_ready_o = arst_n_i & rnd[0];
         // bus request is flop driven, so this pair is what the next rising edge takes
         if (arst_n_i && mem_valid_i && mem_ready_o) begin
            if (mem_wstrb_i == '0) begin
               rnd     = $random(seed);
               rd_pend = 1'b1;
               rd_word = mem_addr_i[`CACHE_BE_ADDR_W-1:`CACHE_BE_NBYTES_W];
               rd_wait = int'(rnd[1:0]);
            end else begin
               for (int b = 0; b < `CACHE_BE_DATA_W/8; b++) begin
                  if (mem_wstrb_i[b]) begin
                     mem[mem_addr_i[`CACHE_BE_ADDR_W-1:`CACHE_BE_NBYTES_W]][8*b +: 8] =
                        mem_wdata_i[8*b +: 8];
                  end
               end
            end
         end
      end
   end

endmodule

//--- verif/cache_be_tb.sv
// memory model gives random ready and read delay from a fixed seed
// expected words come from a local memory mirror that each taken store updates
`timescale 1ns/100ps
`include "cache_be_macros.svh"

module cache_be_tb;

   import cache_be_mem_pkg::*;
   import cache_be_line_pkg::*;

   localparam int WORDS   = 1 << (`CACHE_BE_ADDR_W - `CACHE_BE_NBYTES_W);
   localparam int TIMEOUT = 500;
   localparam int BUS_W   = `CACHE_BE_ADDR_W + `CACHE_BE_DATA_W + `CACHE_BE_DATA_W / 8;

   logic       clk;
   logic       arst_n;
   logic       write_valid;
   word_addr_t write_addr;
   mem_data_t  write_wdata;
   mem_strb_t  write_wstrb;
   logic       write_ready;
   logic       replace_valid;
   line_addr_t replace_addr;
   logic       replace;
   logic       read_valid;
   word_idx_t  read_addr;
   mem_data_t  read_rdata;
   logic       mem_valid;
   mem_addr_t  mem_addr;
   mem_data_t  mem_wdata;
   mem_strb_t  mem_wstrb;
   logic       mem_ready;
   mem_data_t  mem_rdata;
   logic       mem_rvalid;

   // expected memory contents
   mem_data_t       mirror [0:WORDS-1];
   line_addr_t      fill_line;
   mem_data_t       exp_word;
   // last store taken
   word_addr_t      exp_waddr;
   mem_data_t       exp_wdata;
   mem_strb_t       exp_wstrb;
   logic [BUS_W-1:0] exp_bus;
   logic [BUS_W-1:0] act_bus;
   logic            bus_wr;
   logic            rd_busy;
   word_idx_t       exp_idx;
   int              pulses;
   int              bus_writes;
   int              stores_taken;
   int              value_errs = 0;
   int              proto_errs = 0;
   int              check_errs = 0;
   int              timeout_errs = 0;
   integer          seed;
   string           test_name;

   cache_be_top u_dut (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .write_valid_i  (write_valid),
      .write_addr_i   (write_addr),
      .write_wdata_i  (write_wdata),
      .write_wstrb_i  (write_wstrb),
      .write_ready_o  (write_ready),
      .replace_valid_i(replace_valid),
      .replace_addr_i (replace_addr),
      .replace_o      (replace),
      .read_valid_o   (read_valid),
      .read_addr_o    (read_addr),
      .read_rdata_o   (read_rdata),
      .mem_valid_o    (mem_valid),
      .mem_addr_o     (mem_addr),
      .mem_wdata_o    (mem_wdata),
      .mem_wstrb_o    (mem_wstrb),
      .mem_ready_i    (mem_ready),
      .mem_rdata_i    (mem_rdata),
      .mem_rvalid_i   (mem_rvalid)
   );

   cache_be_mem_model u_mem (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .mem_valid_i (mem_valid),
      .mem_addr_i  (mem_addr),
      .mem_wdata_i (mem_wdata),
      .mem_wstrb_i (mem_wstrb),
      .mem_ready_o (mem_ready),
      .mem_rdata_o (mem_rdata),
      .mem_rvalid_o(mem_rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign exp_word = mirror[{fill_line, exp_idx}];
   assign exp_bus  = {exp_waddr, {`CACHE_BE_NBYTES_W{1'b0}}, exp_wdata, exp_wstrb};
   assign act_bus  = {mem_addr, mem_wdata, mem_wstrb};
   // nonzero strobes mark a write
   assign bus_wr   = mem_valid & mem_ready & (mem_wstrb != '0);

   // bus and fill bookkeeping
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_busy    <= 1'b0;
         exp_idx    <= '0;
         pulses     <= 0;
         bus_writes <= 0;
      end else begin
         if (mem_valid && mem_ready && mem_wstrb == '0) begin
            rd_busy <= 1'b1;
         end else if (mem_rvalid) begin
            rd_busy <= 1'b0;
         end
         if (!replace) begin
            exp_idx <= '0;
         end else if (read_valid) begin
            exp_idx <= exp_idx + word_idx_t'(1);
         end
         if (read_valid) begin
            pulses <= pulses + 1;
         end
         if (bus_wr) begin
            bus_writes <= bus_writes + 1;
         end
      end
   end

   hold_req: assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata)
         && $stable(mem_wstrb))
      else begin
         proto_errs++;
         $display("%s: bus request changed before it was accepted", test_name);
      end

   drop_valid: assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid && mem_ready |=> !mem_valid)
      else begin
         proto_errs++;
         $display("%s: bus valid still high after acceptance", test_name);
      end

   // nothing may slip in while a read waits for its data
   no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
      rd_busy |-> !(mem_valid && mem_ready))
      else begin
         proto_errs++;
         $display("%s: bus accepted a request while a read was outstanding", test_name);
      end

   write_owned: assert property (@(posedge clk) disable iff (!arst_n)
      bus_wr |-> stores_taken > bus_writes)
      else begin
         proto_errs++;
         $display("%s: bus write with no store waiting for it", test_name);
      end

   write_value: assert property (@(posedge clk) disable iff (!arst_n)
      bus_wr |-> act_bus == exp_bus)
      else begin
         value_errs++;
         $display("[FAIL] %s expected %h actual %h", test_name, $sampled(exp_bus),
            $sampled(act_bus));
      end

   idx_order: assert property (@(posedge clk) disable iff (!arst_n)
      read_valid |-> read_addr == exp_idx)
      else begin
         value_errs++;
         $display("[FAIL] %s expected %h actual %h", test_name, $sampled(exp_idx),
            $sampled(read_addr));
      end

   word_value: assert property (@(posedge clk) disable iff (!arst_n)
      read_valid |-> read_rdata == exp_word)
      else begin
         value_errs++;
         $display("[FAIL] %s expected %h actual %h", test_name, $sampled(exp_word),
            $sampled(read_rdata));
      end

   fill_end: assert property (@(posedge clk) disable iff (!arst_n)
      read_valid && read_addr == '1 |=> !replace)
      else begin
         proto_errs++;
         $display("%s: replace still high after the last word", test_name);
      end

   fill_mid: assert property (@(posedge clk) disable iff (!arst_n)
      read_valid && read_addr != '1 |=> replace)
      else begin
         proto_errs++;
         $display("%s: replace dropped before the last word", test_name);
      end

   // called and left on a falling edge
   task automatic store_word(input word_addr_t addr, input mem_data_t data,
                             input mem_strb_t strb);
      int waited;
      waited      = 0;
      write_valid = 1'b1;
      write_addr  = addr;
      write_wdata = data;
      write_wstrb = strb;
      while (!write_ready && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!write_ready) begin
         timeout_errs++;
         $display("%s: store to %h was never taken", test_name, addr);
         write_valid = 1'b0;
         return;
      end
      // taken on the coming rising edge
      for (int b = 0; b < `CACHE_BE_DATA_W/8; b++) begin
         if (strb[b]) begin
            mirror[addr][8*b +: 8] = data[8*b +: 8];
         end
      end
      exp_waddr = addr;
      exp_wdata = data;
      exp_wstrb = strb;
      stores_taken++;
      @(negedge clk);
      write_valid = 1'b0;
      waited      = 0;
      while (!write_ready && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!write_ready) begin
         timeout_errs++;
         $display("%s: write ready never came back after the store", test_name);
      end
   endtask

   task automatic run_fill(input line_addr_t line);
      int waited;
      int start;
      waited        = 0;
      fill_line     = line;
      start         = pulses;
      replace_valid = 1'b1;
      replace_addr  = line;
      while (!replace && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      replace_valid = 1'b0;
      if (!replace) begin
         timeout_errs++;
         $display("%s: fill of line %h never started", test_name, line);
         return;
      end
      waited = 0;
      while (replace && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (replace) begin
         timeout_errs++;
         $display("%s: fill of line %h never finished", test_name, line);
      end else begin
         assert (pulses - start == 4)
            else begin
               check_errs++;
               $display("[FAIL] %s expected %0d actual %0d", test_name, 4, pulses - start);
            end
      end
   endtask

   initial begin
      mem_strb_t  strbs [4];
      logic [31:0] rnd;
      line_addr_t line;
      mem_strb_t  strb;
      strbs         = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
      seed          = 62;
      stores_taken  = 0;
      test_name     = "reset";
      fill_line     = '0;
      exp_waddr     = '0;
      exp_wdata     = '0;
      exp_wstrb     = '0;
      // same pattern as the memory model with address over inverted address
      for (int i = 0; i < WORDS; i++) begin
         mirror[i] = {16'(i << 2), ~16'(i << 2)};
      end
      arst_n        = 1'b0;
      write_valid   = 1'b0;
      write_addr    = '0;
      write_wdata   = '0;
      write_wstrb   = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      assert ({write_ready, replace, read_valid, mem_valid} == 4'b1000)
         else begin
            check_errs++;
            $display("[FAIL] %s expected %b actual %b", test_name, 4'b1000,
               {write_ready, replace, read_valid, mem_valid});
         end

      test_name = "single_store";
      rnd       = $random(seed);
      store_word(14'h0105, rnd, 4'hf);

      test_name = "line_fill";
      run_fill(12'h041);

      // partial lanes over the initial pattern
      test_name = "merged_store";
      for (int w = 0; w < 4; w++) begin
         rnd = $random(seed);
         store_word({12'h042, w[1:0]}, rnd, strbs[w]);
      end
      run_fill(12'h042);

      test_name = "random_ready";
      repeat (6) begin
         rnd  = $random(seed);
         line = line_addr_t'(rnd[27:16]);
         strb = mem_strb_t'(rnd[7:4]);
         if (strb == '0) begin
            strb = '1;
         end
         rnd = $random(seed);
         store_word({line, rnd[1:0]}, rnd, strb);
         run_fill(line);
      end

      // stores wait behind the fill and a second fill reads them back
      test_name = "store_during_fill";
      fork
         run_fill(12'h050);
         begin
            repeat (3) @(negedge clk);
            for (int w = 0; w < 3; w++) begin
               rnd = $random(seed);
               store_word({12'h060, w[1:0]}, rnd, 4'hf);
            end
         end
      join
      run_fill(12'h060);
      assert (bus_writes == stores_taken)
         else begin
            check_errs++;
            $display("[FAIL] write_count expected %0d actual %0d", stores_taken, bus_writes);
         end

      repeat (2) @(negedge clk);
      $display("errors: value %0d, protocol %0d, check %0d, timeout %0d",
         value_errs, proto_errs, check_errs, timeout_errs);
      if (value_errs + proto_errs + check_errs + timeout_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
